//--- logic/mem_settings.svh
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// address and data word widths
`define MEM_ADDR_W 32
`define MEM_DATA_W 32

// on-chip memory size in words
`define MEM_DEPTH_WORDS 256

// width of the wait-state field
`define MEM_WAIT_W 4

// config register values after reset
`define MEM_RESET_OFFSET 32'h0000_0000
`define MEM_RESET_WAIT 4'd2

`endif

//--- logic/mem_bus_pkg.sv
package mem_bus_pkg;

    // request unit FSM
    typedef enum logic [1:0] {
        ST_IDLE       = 2'd0,
        ST_DATA_WRITE = 2'd1,  // store on the bus
        ST_DATA_READ  = 2'd2,  // load on the bus
        ST_INSTR_READ = 2'd3   // instruction fetch on the bus
    } req_state_t;

    // kind of a completed bus transfer
    typedef enum logic [1:0] {
        OP_FETCH = 2'd0,
        OP_LOAD  = 2'd1,
        OP_STORE = 2'd2
    } bus_op_t;

    // operation kind of a busy FSM state
    function automatic bus_op_t state_to_op(input req_state_t st);
        bus_op_t op;
        case (st)
            ST_DATA_WRITE: op = OP_STORE;
            ST_DATA_READ:  op = OP_LOAD;
            default:       op = OP_FETCH;
        endcase
        return op;
    endfunction

endpackage

//--- logic/cfg_pkg.sv
package cfg_pkg;

    // register index from byte address bits [5:2]
    typedef enum logic [3:0] {
        REG_CTRL      = 4'd0,  // 0x00 with enable in bit 0
        REG_BASE      = 4'd1,  // 0x04 base offset
        REG_WAIT      = 4'd2,  // 0x08 memory wait states
        REG_FETCH_CNT = 4'd3,  // 0x0c
        REG_LOAD_CNT  = 4'd4,  // 0x10
        REG_STORE_CNT = 4'd5   // 0x14
    } reg_addr_t;

    // AXI response codes in use
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_t;

endpackage

//--- logic/wb_bus_if.sv
`include "mem_settings.svh"

interface wb_bus_if;

    logic                   cyc;    // transfer in progress
    logic                   we;     // 1 = write
    logic [`MEM_ADDR_W-1:0] adr;    // byte address
    logic [`MEM_DATA_W-1:0] dat_w;  // master to slave
    logic [`MEM_DATA_W-1:0] dat_r;  // slave to master and valid with ack
    logic                   ack;    // one-cycle completion

    modport master (
        output cyc,
        output we,
        output adr,
        output dat_w,
        input  dat_r,
        input  ack
    );

    modport slave (
        input  cyc,
        input  we,
        input  adr,
        input  dat_w,
        output dat_r,
        output ack
    );

endinterface

//--- logic/request_unit.sv
`include "mem_settings.svh"

module request_unit (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   enable_i,
    input  logic [`MEM_ADDR_W-1:0] base_offset_i,
    // CPU side
    input  logic                   fetch_req_i,
    input  logic                   mem_read_i,
    input  logic                   mem_write_i,
    input  logic [`MEM_ADDR_W-1:0] instr_addr_i,
    input  logic [`MEM_ADDR_W-1:0] data_addr_i,
    input  logic [`MEM_DATA_W-1:0] write_data_i,
    output logic [`MEM_DATA_W-1:0] instruction_o,
    output logic [`MEM_DATA_W-1:0] read_data_o,
    output logic                   i_hit_o,
    output logic                   d_hit_o,
    // completion report for the counters
    output logic                   done_valid_o,
    output mem_bus_pkg::bus_op_t   done_op_o,
    wb_bus_if.master               bus
);
    import mem_bus_pkg::*;

    req_state_t             state;
    req_state_t             next_state;
    logic                   data_ok;   // data request may start
    logic                   fetch_ok;  // fetch may start
    logic                   start;     // leaving idle on this edge
    logic                   finish;    // ack seen on this edge
    logic                   cyc_q;
    logic                   we_q;
    logic [`MEM_ADDR_W-1:0] cpu_addr;
    logic [`MEM_ADDR_W-1:0] adr_q;
    logic [`MEM_DATA_W-1:0] dat_w_q;

    // the CPU still holds its request during the hit cycle
    assign data_ok  = enable_i && !d_hit_o;
    assign fetch_ok = enable_i && !i_hit_o;

    // priority is store, load, fetch
    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: begin
                if (mem_write_i && data_ok) begin
                    next_state = ST_DATA_WRITE;
                end else if (mem_read_i && data_ok) begin
                    next_state = ST_DATA_READ;
                end else if (fetch_req_i && fetch_ok) begin
                    next_state = ST_INSTR_READ;
                end
            end
            default: begin
                if (bus.ack) begin
                    next_state = ST_IDLE;  // enable is only looked at in idle
                end
            end
        endcase
    end

    assign start    = (state == ST_IDLE) && (next_state != ST_IDLE);
    assign finish   = (state != ST_IDLE) && bus.ack;
    assign cpu_addr = (next_state == ST_INSTR_READ) ? instr_addr_i : data_addr_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= ST_IDLE;
            cyc_q        <= 1'b0;
            we_q         <= 1'b0;
            i_hit_o      <= 1'b0;
            d_hit_o      <= 1'b0;
            done_valid_o <= 1'b0;
        end else begin
            state        <= next_state;
            i_hit_o      <= finish && (state == ST_INSTR_READ);
            d_hit_o      <= finish && (state != ST_INSTR_READ);
            done_valid_o <= finish;
            if (start) begin
                cyc_q <= 1'b1;
                we_q  <= (next_state == ST_DATA_WRITE);
            end else if (finish) begin
                cyc_q <= 1'b0;  // gives one idle cycle between transfers
                we_q  <= 1'b0;
            end
        end
    end

    // address and data held stable for the whole transfer
    always_ff @(posedge clk) begin
        if (start) begin
            adr_q   <= cpu_addr + base_offset_i;  // memory sees translated address
            dat_w_q <= write_data_i;
        end
        if (finish) begin
            done_op_o <= state_to_op(state);
            if (state == ST_INSTR_READ) begin
                instruction_o <= bus.dat_r;
            end
            if (state == ST_DATA_READ) begin
                read_data_o <= bus.dat_r;
            end
        end
    end

    assign bus.cyc   = cyc_q;
    assign bus.we    = we_q;
    assign bus.adr   = adr_q;
    assign bus.dat_w = dat_w_q;

endmodule

//--- logic/bus_ctrl_regs.sv
`include "mem_settings.svh"

module bus_ctrl_regs (
    input  logic                     clk,
    input  logic                     rst,
    // AXI4-Lite write channels
    input  logic [`MEM_ADDR_W-1:0]   awaddr_i,
    input  logic                     awvalid_i,
    output logic                     awready_o,
    input  logic [`MEM_DATA_W-1:0]   wdata_i,
    input  logic [`MEM_DATA_W/8-1:0] wstrb_i,
    input  logic                     wvalid_i,
    output logic                     wready_o,
    output cfg_pkg::axi_resp_t       bresp_o,
    output logic                     bvalid_o,
    input  logic                     bready_i,
    // AXI4-Lite read channels
    input  logic [`MEM_ADDR_W-1:0]   araddr_i,
    input  logic                     arvalid_i,
    output logic                     arready_o,
    output logic [`MEM_DATA_W-1:0]   rdata_o,
    output cfg_pkg::axi_resp_t       rresp_o,
    output logic                     rvalid_o,
    input  logic                     rready_i,
    // completions from the request unit
    input  logic                     done_valid_i,
    input  mem_bus_pkg::bus_op_t     done_op_i,
    // configuration
    output logic                     enable_o,
    output logic [`MEM_ADDR_W-1:0]   base_offset_o,
    output logic [`MEM_WAIT_W-1:0]   wait_states_o
);
    import cfg_pkg::*;
    import mem_bus_pkg::*;

    logic                   ready_en;  // high from the first cycle after reset
    logic                   wr_fire;
    logic                   rd_fire;
    logic                   wr_known;
    logic                   rd_known;
    reg_addr_t              wr_idx;
    reg_addr_t              rd_idx;
    logic [`MEM_DATA_W-1:0] rd_value;
    logic [`MEM_DATA_W-1:0] fetch_cnt;
    logic [`MEM_DATA_W-1:0] load_cnt;
    logic [`MEM_DATA_W-1:0] store_cnt;

    // only the six words at the bottom of the window exist
    function automatic logic reg_known(input logic [`MEM_ADDR_W-1:0] addr);
        logic [3:0] idx;
        idx = addr[5:2];
        return (addr[`MEM_ADDR_W-1:6] == '0) && (idx <= REG_STORE_CNT);
    endfunction

    assign wr_idx   = reg_addr_t'(awaddr_i[5:2]);
    assign rd_idx   = reg_addr_t'(araddr_i[5:2]);
    assign wr_known = reg_known(awaddr_i);
    assign rd_known = reg_known(araddr_i);

    // address and data taken together with one response outstanding
    assign wr_fire   = ready_en && !bvalid_o && awvalid_i && wvalid_i;
    assign awready_o = wr_fire;
    assign wready_o  = wr_fire;
    assign arready_o = ready_en && !rvalid_o;
    assign rd_fire   = arvalid_i && arready_o;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ready_en      <= 1'b0;
            enable_o      <= 1'b0;
            base_offset_o <= `MEM_RESET_OFFSET;
            wait_states_o <= `MEM_RESET_WAIT;
            bvalid_o      <= 1'b0;
            bresp_o       <= RESP_OKAY;
        end else begin
            ready_en <= 1'b1;
            if (bvalid_o && bready_i) begin
                bvalid_o <= 1'b0;
            end
            if (wr_fire) begin
                bvalid_o <= 1'b1;
                bresp_o  <= wr_known ? RESP_OKAY : RESP_SLVERR;
                if (wr_known) begin
                    case (wr_idx)
                        REG_CTRL: begin
                            if (wstrb_i[0]) begin
                                enable_o <= wdata_i[0];
                            end
                        end
                        REG_BASE: begin
                            for (int b = 0; b < `MEM_DATA_W/8; b++) begin
                                if (wstrb_i[b]) begin
                                    base_offset_o[b*8 +: 8] <= wdata_i[b*8 +: 8];
                                end
                            end
                        end
                        REG_WAIT: begin
                            if (wstrb_i[0]) begin
                                wait_states_o <= wdata_i[`MEM_WAIT_W-1:0];
                            end
                        end
                        default: ;  // counters are read-only
                    endcase
                end
            end
        end
    end

    // wrapping completion counters
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fetch_cnt <= '0;
            load_cnt  <= '0;
            store_cnt <= '0;
        end else if (done_valid_i) begin
            case (done_op_i)
                OP_FETCH: fetch_cnt <= fetch_cnt + 1'b1;
                OP_LOAD:  load_cnt  <= load_cnt + 1'b1;
                OP_STORE: store_cnt <= store_cnt + 1'b1;
                default:  ;
            endcase
        end
    end

    always_comb begin
        rd_value = '0;  // unknown offsets read zero
        if (rd_known) begin
            case (rd_idx)
                REG_CTRL:      rd_value[0] = enable_o;
                REG_BASE:      rd_value = base_offset_o;
                REG_WAIT:      rd_value[`MEM_WAIT_W-1:0] = wait_states_o;
                REG_FETCH_CNT: rd_value = fetch_cnt;
                REG_LOAD_CNT:  rd_value = load_cnt;
                REG_STORE_CNT: rd_value = store_cnt;
                default:       rd_value = '0;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rvalid_o <= 1'b0;
            rresp_o  <= RESP_OKAY;
            rdata_o  <= '0;
        end else begin
            if (rvalid_o && rready_i) begin
                rvalid_o <= 1'b0;
            end
            if (rd_fire) begin
                rvalid_o <= 1'b1;
                rdata_o  <= rd_value;
                rresp_o  <= rd_known ? RESP_OKAY : RESP_SLVERR;
            end
        end
    end

endmodule

//--- logic/wb_memory.sv
`include "mem_settings.svh"

module wb_memory (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`MEM_WAIT_W-1:0] wait_states_i,
    wb_bus_if.slave                bus
);
    localparam int IDX_W = $clog2(`MEM_DEPTH_WORDS);

    logic [`MEM_DATA_W-1:0] mem [`MEM_DEPTH_WORDS];
    logic [IDX_W-1:0]       word_idx;
    logic [`MEM_WAIT_W-1:0] wait_cnt;  // cycles left before ack
    logic                   busy;      // counting down wait states
    logic                   begin_xfer;
    logic                   fire;      // ack rises on this edge
    logic                   ack_q;
    logic [`MEM_DATA_W-1:0] dat_r_q;

    // upper address bits ignored so the window wraps
    assign word_idx = bus.adr[IDX_W+1:2];

    // no restart during the ack cycle itself
    assign begin_xfer = bus.cyc && !busy && !ack_q;
    assign fire       = busy ? (wait_cnt == '0) : (begin_xfer && (wait_states_i == '0));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `MEM_DEPTH_WORDS; i++) begin
                mem[i] <= '0;
            end
            busy     <= 1'b0;
            wait_cnt <= '0;
            ack_q    <= 1'b0;
            dat_r_q  <= '0;
        end else begin
            ack_q <= fire;  // single-cycle pulse
            if (fire) begin
                busy    <= 1'b0;
                dat_r_q <= mem[word_idx];
                if (bus.we) begin
                    mem[word_idx] <= bus.dat_w;
                end
            end else if (busy) begin
                wait_cnt <= wait_cnt - 1'b1;
            end else if (begin_xfer) begin
                busy     <= 1'b1;
                wait_cnt <= wait_states_i - 1'b1;  // first wait cycle is this one
            end
        end
    end

    assign bus.ack   = ack_q;
    assign bus.dat_r = dat_r_q;

endmodule

//--- logic/mem_subsystem_top.sv
`include "mem_settings.svh"

module mem_subsystem_top (
    input  logic                     clk,
    input  logic                     rst,
    // CPU side
    input  logic                     fetch_req_i,
    input  logic                     mem_read_i,
    input  logic                     mem_write_i,
    input  logic [`MEM_ADDR_W-1:0]   instr_addr_i,
    input  logic [`MEM_ADDR_W-1:0]   data_addr_i,
    input  logic [`MEM_DATA_W-1:0]   write_data_i,
    output logic [`MEM_DATA_W-1:0]   instruction_o,
    output logic [`MEM_DATA_W-1:0]   read_data_o,
    output logic                     i_hit_o,
    output logic                     d_hit_o,
    // AXI4-Lite config port
    input  logic [`MEM_ADDR_W-1:0]   awaddr_i,
    input  logic                     awvalid_i,
    output logic                     awready_o,
    input  logic [`MEM_DATA_W-1:0]   wdata_i,
    input  logic [`MEM_DATA_W/8-1:0] wstrb_i,
    input  logic                     wvalid_i,
    output logic                     wready_o,
    output cfg_pkg::axi_resp_t       bresp_o,
    output logic                     bvalid_o,
    input  logic                     bready_i,
    input  logic [`MEM_ADDR_W-1:0]   araddr_i,
    input  logic                     arvalid_i,
    output logic                     arready_o,
    output logic [`MEM_DATA_W-1:0]   rdata_o,
    output cfg_pkg::axi_resp_t       rresp_o,
    output logic                     rvalid_o,
    input  logic                     rready_i
);
    import mem_bus_pkg::*;

    logic                   enable;
    logic [`MEM_ADDR_W-1:0] base_offset;
    logic [`MEM_WAIT_W-1:0] wait_states;
    logic                   done_valid;
    bus_op_t                done_op;

    wb_bus_if wb_bus ();

    request_unit request_unit_inst (
        .clk           (clk),
        .rst           (rst),
        .enable_i      (enable),
        .base_offset_i (base_offset),
        .fetch_req_i   (fetch_req_i),
        .mem_read_i    (mem_read_i),
        .mem_write_i   (mem_write_i),
        .instr_addr_i  (instr_addr_i),
        .data_addr_i   (data_addr_i),
        .write_data_i  (write_data_i),
        .instruction_o (instruction_o),
        .read_data_o   (read_data_o),
        .i_hit_o       (i_hit_o),
        .d_hit_o       (d_hit_o),
        .done_valid_o  (done_valid),
        .done_op_o     (done_op),
        .bus           (wb_bus.master)
    );

    bus_ctrl_regs bus_ctrl_regs_inst (
        .clk           (clk),
        .rst           (rst),
        .awaddr_i      (awaddr_i),
        .awvalid_i     (awvalid_i),
        .awready_o     (awready_o),
        .wdata_i       (wdata_i),
        .wstrb_i       (wstrb_i),
        .wvalid_i      (wvalid_i),
        .wready_o      (wready_o),
        .bresp_o       (bresp_o),
        .bvalid_o      (bvalid_o),
        .bready_i      (bready_i),
        .araddr_i      (araddr_i),
        .arvalid_i     (arvalid_i),
        .arready_o     (arready_o),
        .rdata_o       (rdata_o),
        .rresp_o       (rresp_o),
        .rvalid_o      (rvalid_o),
        .rready_i      (rready_i),
        .done_valid_i  (done_valid),
        .done_op_i     (done_op),
        .enable_o      (enable),
        .base_offset_o (base_offset),
        .wait_states_o (wait_states)
    );

    wb_memory wb_memory_inst (
        .clk           (clk),
        .rst           (rst),
        .wait_states_i (wait_states),
        .bus           (wb_bus.slave)
    );

endmodule

//--- bench/tb_mem_subsystem.sv
`include "mem_settings.svh"

module tb_mem_subsystem;
    import cfg_pkg::*;

    localparam int WAIT_LIMIT = 200;  // cycles allowed for any handshake

    logic                     clk;
    logic                     rst;
    logic                     fetch_req;
    logic                     mem_read;
    logic                     mem_write;
    logic [`MEM_ADDR_W-1:0]   instr_addr;
    logic [`MEM_ADDR_W-1:0]   data_addr;
    logic [`MEM_DATA_W-1:0]   write_data;
    logic [`MEM_DATA_W-1:0]   instruction_o;
    logic [`MEM_DATA_W-1:0]   read_data_o;
    logic                     i_hit_o;
    logic                     d_hit_o;
    logic [`MEM_ADDR_W-1:0]   awaddr;
    logic                     awvalid;
    logic                     awready_o;
    logic [`MEM_DATA_W-1:0]   wdata;
    logic [`MEM_DATA_W/8-1:0] wstrb;
    logic                     wvalid;
    logic                     wready_o;
    axi_resp_t                bresp_o;
    logic                     bvalid_o;
    logic                     bready;
    logic [`MEM_ADDR_W-1:0]   araddr;
    logic                     arvalid;
    logic                     arready_o;
    logic [`MEM_DATA_W-1:0]   rdata_o;
    axi_resp_t                rresp_o;
    logic                     rvalid_o;
    logic                     rready;
    logic [`MEM_DATA_W-1:0]   last_instr;  // word of the latest fetch
    logic                     fetch_seen;  // a fetch has completed

    mem_subsystem_top mem_subsystem_top_inst (
        .clk           (clk),
        .rst           (rst),
        .fetch_req_i   (fetch_req),
        .mem_read_i    (mem_read),
        .mem_write_i   (mem_write),
        .instr_addr_i  (instr_addr),
        .data_addr_i   (data_addr),
        .write_data_i  (write_data),
        .instruction_o (instruction_o),
        .read_data_o   (read_data_o),
        .i_hit_o       (i_hit_o),
        .d_hit_o       (d_hit_o),
        .awaddr_i      (awaddr),
        .awvalid_i     (awvalid),
        .awready_o     (awready_o),
        .wdata_i       (wdata),
        .wstrb_i       (wstrb),
        .wvalid_i      (wvalid),
        .wready_o      (wready_o),
        .bresp_o       (bresp_o),
        .bvalid_o      (bvalid_o),
        .bready_i      (bready),
        .araddr_i      (araddr),
        .arvalid_i     (arvalid),
        .arready_o     (arready_o),
        .rdata_o       (rdata_o),
        .rresp_o       (rresp_o),
        .rvalid_o      (rvalid_o),
        .rready_i      (rready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] time %0t %s expected %08h actual %08h",
                     $time, name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic give_up(input string what);
        $display("timed out after %0d cycles waiting for %s", WAIT_LIMIT, what);
        $display("Simulation failed");
        $fatal(1, "handshake timeout");
    endtask

    // instruction_o keeps the last fetched word across data transfers
    task automatic check_instr_held();
        if (fetch_seen) begin
            check_value("instruction_o held", last_instr, instruction_o);
        end
    endtask

    // outputs read right after the edge still show the values the DUT saw at it
    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [31:0] exp_resp);
        int waited;
        @(posedge clk);
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= data;
        wstrb   <= 4'hf;
        wvalid  <= 1'b1;
        waited = 0;
        @(posedge clk);
        while (!(awready_o && wready_o)) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                give_up("awready and wready");
            end
            @(posedge clk);
        end
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        waited = 0;
        while (!bvalid_o) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                give_up("bvalid");
            end
            @(posedge clk);
        end
        check_value("bresp_o", exp_resp, {30'b0, bresp_o});  // bready is always high
    endtask

    task automatic axi_read(input logic [31:0] addr, input logic [31:0] exp_resp,
                            input logic [31:0] exp_data);
        int waited;
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        waited = 0;
        @(posedge clk);
        while (!arready_o) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                give_up("arready");
            end
            @(posedge clk);
        end
        arvalid <= 1'b0;
        waited = 0;
        while (!rvalid_o) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                give_up("rvalid");
            end
            @(posedge clk);
        end
        check_value("rresp_o", exp_resp, {30'b0, rresp_o});
        check_value("rdata_o", exp_data, rdata_o);
    endtask

    task automatic wait_for_d_hit();
        int waited;
        waited = 0;
        @(posedge clk);
        while (!d_hit_o) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                give_up("d_hit");
            end
            @(posedge clk);
        end
    endtask

    task automatic wait_for_i_hit();
        int waited;
        waited = 0;
        @(posedge clk);
        while (!i_hit_o) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                give_up("i_hit");
            end
            @(posedge clk);
        end
    endtask

    task automatic cpu_store(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk);
        data_addr  <= addr;
        write_data <= data;
        mem_write  <= 1'b1;
        wait_for_d_hit();
        mem_write <= 1'b0;  // request held until the hit
        check_instr_held();
        @(posedge clk);
        check_value("d_hit_o", 32'd0, {31'b0, d_hit_o});  // one pulse per request
    endtask

    task automatic cpu_load(input logic [31:0] addr, input logic [31:0] exp_data);
        @(posedge clk);
        data_addr <= addr;
        mem_read  <= 1'b1;
        wait_for_d_hit();
        mem_read <= 1'b0;
        check_value("read_data_o", exp_data, read_data_o);
        check_instr_held();
        @(posedge clk);
        check_value("d_hit_o", 32'd0, {31'b0, d_hit_o});
    endtask

    task automatic cpu_fetch(input logic [31:0] addr, input logic [31:0] exp_instr);
        @(posedge clk);
        instr_addr <= addr;
        fetch_req  <= 1'b1;
        wait_for_i_hit();
        fetch_req <= 1'b0;
        check_value("instruction_o", exp_instr, instruction_o);
        last_instr = exp_instr;
        fetch_seen = 1'b1;
        @(posedge clk);
        check_value("i_hit_o", 32'd0, {31'b0, i_hit_o});
    endtask

    // the store must win over a fetch raised in the same cycle
    task automatic store_and_fetch(input logic [31:0] addr, input logic [31:0] data,
                                   input logic [31:0] exp_instr);
        int waited;
        @(posedge clk);
        data_addr  <= addr;
        write_data <= data;
        mem_write  <= 1'b1;
        instr_addr <= addr;
        fetch_req  <= 1'b1;
        waited = 0;
        @(posedge clk);
        while (!d_hit_o && !i_hit_o) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                give_up("the first hit of a store and a fetch");
            end
            @(posedge clk);
        end
        check_value("d_hit_o before i_hit_o", 32'd1, {31'b0, d_hit_o});
        check_instr_held();
        mem_write <= 1'b0;
        wait_for_i_hit();
        fetch_req <= 1'b0;
        check_value("instruction_o", exp_instr, instruction_o);
        last_instr = exp_instr;
        fetch_seen = 1'b1;
    endtask

    task automatic run_step(input string op, input logic [31:0] addr,
                            input logic [31:0] data, input logic [31:0] exp_val);
        if (op == "axi_wr") begin
            axi_write(addr, data, exp_val);
        end else if (op == "axi_rd") begin
            axi_read(addr, data, exp_val);  // data column holds the response
        end else if (op == "store") begin
            cpu_store(addr, data);
        end else if (op == "load") begin
            cpu_load(addr, exp_val);
        end else if (op == "fetch") begin
            cpu_fetch(addr, exp_val);
        end else if (op == "store_fetch") begin
            store_and_fetch(addr, data, exp_val);
        end else begin
            $display("unknown operation %s in the stimulus file", op);
            $display("Simulation failed");
            $fatal(1, "bad stimulus");
        end
    endtask

    initial begin
        string       line;
        string       op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] exp_val;
        int          fd;
        int          n;
        int          line_no;

        rst        = 1'b1;
        fetch_req  = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        instr_addr = '0;
        data_addr  = '0;
        write_data = '0;
        awaddr     = '0;
        awvalid    = 1'b0;
        wdata      = '0;
        wstrb      = '0;
        wvalid     = 1'b0;
        bready     = 1'b1;
        araddr     = '0;
        arvalid    = 1'b0;
        rready     = 1'b1;
        last_instr = '0;
        fetch_seen = 1'b0;

        repeat (10) @(posedge clk);
        rst <= 1'b0;

        fd = $fopen("bench/mem_subsystem_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open bench/mem_subsystem_tests.txt");
            $display("Simulation failed");
            $fatal(1, "no stimulus file");
        end
        line_no = 0;
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            line_no++;
            if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
                n = $sscanf(line, "%s %h %h %h", op, addr, data, exp_val);
                if (n != 4) begin
                    $display("line %0d of the stimulus file has %0d fields, not 4",
                             line_no, n);
                    $display("Simulation failed");
                    $fatal(1, "bad stimulus");
                end else begin
                    run_step(op, addr, data, exp_val);
                end
            end
        end
        $fclose(fd);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- bench/mem_subsystem_tests.txt
# op addr data expect, all hex. axi_wr: data written, expect is bresp (0 OKAY, 2 SLVERR)
# axi_rd: data is the expected rresp, expect is rdata. store/load/fetch: expect is the word
axi_rd 00000000 0 00000000
axi_rd 00000008 0 00000002
axi_rd 00000018 2 00000000
axi_wr 00000018 12345678 2
axi_rd 00000018 2 00000000
axi_wr 00000004 000000a0 0
axi_rd 00000004 0 000000a0
axi_wr 00000004 00000000 0
axi_wr 0000000c 00000055 0
axi_rd 0000000c 0 00000000
axi_wr 00000000 00000001 0
axi_rd 00000000 0 00000001
store 00000010 deadbeef 0
store 00000014 cafef00d 0
load 00000010 0 deadbeef
load 00000014 0 cafef00d
fetch 00000014 0 cafef00d
fetch 00000010 0 deadbeef
store 00000044 a5a5a5a5 0
axi_wr 00000004 00000004 0
load 00000040 0 a5a5a5a5
axi_wr 00000004 00000000 0
axi_wr 00000008 00000000 0
axi_rd 00000008 0 00000000
store 00000020 11112222 0
load 00000020 0 11112222
axi_wr 00000008 00000007 0
axi_rd 00000008 0 00000007
load 00000020 0 11112222
store_fetch 00000030 33334444 33334444
load 00000030 0 33334444
axi_rd 0000000c 0 00000003
axi_rd 00000010 0 00000006
axi_rd 00000014 0 00000005

//--- compile.f
+incdir+logic
logic/mem_bus_pkg.sv
logic/cfg_pkg.sv
logic/wb_bus_if.sv
logic/request_unit.sv
logic/bus_ctrl_regs.sv
logic/wb_memory.sv
logic/mem_subsystem_top.sv
bench/tb_mem_subsystem.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing \
    --top-module tb_mem_subsystem \
    -f compile.f \
    -o sim_tb_mem_subsystem

./obj_dir/sim_tb_mem_subsystem
